// ==== design/scope_pkg.sv ====
//----------------------------
// Widths, capture depth and FSM encodings for the scope front end
// The depth is fixed at build time and must stay a power of two
//----------------------------
package scope_pkg;

    // Capture depth in samples, as a power of two
    localparam int BUF_DEPTH_LOG2 = 6;
    localparam int BUF_DEPTH = 1 << BUF_DEPTH_LOG2;

    // Four 16-bit samples make one 64-bit write beat
    localparam int SAMPLES_PER_BEAT = 4;
    localparam int LANE_BITS = $clog2(SAMPLES_PER_BEAT);

    typedef logic [15:0] sample_t;
    typedef logic [7:0] dest_t;
    typedef logic [BUF_DEPTH_LOG2-1:0] buf_addr_t;
    typedef logic [31:0] addr_t;
    typedef logic [63:0] beat_t;

    // One bit wider than a buffer index so that a full count of BUF_DEPTH fits
    typedef logic [BUF_DEPTH_LOG2:0] fill_cnt_t;

    typedef enum logic [1:0] {
        ARMED,
        POST,
        HOLD
    } capture_state_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DONE
    } readout_state_t;

endpackage

// ==== design/capture_mem_if.sv ====
//----------------------------
// Link between the capture memory and the readout stage
// rd_data lags rd_addr by one clock
//----------------------------
interface capture_mem_if;
    import scope_pkg::*;

    // High for as long as a finished window is held
    logic full;
    // Oldest sample of the held window
    buf_addr_t start_addr;
    buf_addr_t rd_addr;
    sample_t rd_data;
    // Single-cycle strobe that hands the memory back for a new capture
    logic rearm;

    modport buffer (
        output full,
        output start_addr,
        output rd_data,
        input  rd_addr,
        input  rearm
    );

    modport reader (
        input  full,
        input  start_addr,
        input  rd_data,
        output rd_addr,
        output rearm
    );

endinterface

// ==== design/sample_stream_if.sv ====
//----------------------------
// Replayed sample stream, readout to DMA writer
// No ready signal, so the sink takes every valid sample
//----------------------------
interface sample_stream_if;
    import scope_pkg::*;

    logic valid;
    sample_t data;
    dest_t dest;
    // Set on the final sample of a capture window
    logic last;

    modport source (
        output valid,
        output data,
        output dest,
        output last
    );

    modport sink (
        input valid,
        input data,
        input dest,
        input last
    );

endinterface

// ==== design/capture_buffer.sv ====
//----------------------------
// Circular capture memory with a pre-trigger window
// trigger_point must be below BUF_DEPTH and stable from trigger to full
// Input is refused while a window is held
//----------------------------
module capture_buffer (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  scope_pkg::sample_t   in_data,
    input  scope_pkg::dest_t     in_dest,
    input  logic                 trigger,
    input  scope_pkg::buf_addr_t trigger_point,
    capture_mem_if.buffer        mem,
    output scope_pkg::dest_t     capture_dest
);
    import scope_pkg::*;

    capture_state_t state;
    sample_t ram [BUF_DEPTH];
    buf_addr_t wr_ptr;
    fill_cnt_t armed_cnt;
    fill_cnt_t post_left;
    fill_cnt_t post_len;
    logic accept;
    logic trig_ok;
    logic dest_wait;

    // The memory takes samples in every state but HOLD
    assign in_ready = (state != HOLD);
    assign accept = in_valid && in_ready;

    // A trigger counts only once enough history exists for the pre-trigger part
    assign trig_ok = (state == ARMED) && trigger && (armed_cnt >= {1'b0, trigger_point});

    // Samples still owed once the trigger is taken
    // If a sample lands with the strobe it is T and is already paid for
    assign post_len = fill_cnt_t'(BUF_DEPTH) - {1'b0, trigger_point}
                      - {{BUF_DEPTH_LOG2{1'b0}}, accept};

    assign mem.full = (state == HOLD);
    // After the final write the pointer sits on the oldest sample
    assign mem.start_addr = wr_ptr;

    always_ff @(posedge clock) begin
        if (accept) begin
            ram[wr_ptr] <= in_data;
        end
        // Registered read port for the readout stage
        mem.rd_data <= ram[mem.rd_addr];
        // Latch dest from T, which may come with the strobe or later
        if (accept && (trig_ok || ((state == POST) && dest_wait))) begin
            capture_dest <= in_dest;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ARMED;
            wr_ptr <= '0;
            armed_cnt <= '0;
            post_left <= '0;
            dest_wait <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // History count saturates at the buffer depth
            if (accept && (armed_cnt != fill_cnt_t'(BUF_DEPTH))) begin
                armed_cnt <= armed_cnt + 1'b1;
            end
            case (state)
                ARMED: begin
                    if (trig_ok) begin
                        post_left <= post_len;
                        dest_wait <= !accept;
                        // trigger_point of BUF_DEPTH-1 ends the window on T itself
                        state <= (post_len == '0) ? HOLD : POST;
                    end
                end
                POST: begin
                    if (accept) begin
                        post_left <= post_left - 1'b1;
                        dest_wait <= 1'b0;
                        if (post_left == fill_cnt_t'(1)) begin
                            state <= HOLD;
                        end
                    end
                end
                HOLD: begin
                    // No samples arrive here, so the count can be cleared safely
                    if (mem.rearm) begin
                        state <= ARMED;
                        armed_cnt <= '0;
                    end
                end
                default: begin
                    state <= ARMED;
                end
            endcase
        end
    end

endmodule

// ==== design/capture_readout.sv ====
//----------------------------
// Replays a held window, oldest sample first
// First sample comes two clocks after full is registered here
// Output cannot be stalled
//----------------------------
module capture_readout (
    input  logic             clock,
    input  logic             rst_n,
    capture_mem_if.reader    mem,
    input  scope_pkg::dest_t capture_dest,
    sample_stream_if.source  out
);
    import scope_pkg::*;

    readout_state_t state;
    buf_addr_t rd_cnt;
    logic full_seen;
    logic full_seen_q;
    logic start;

    // Replay starts on the rising edge of the registered full flag
    assign start = full_seen && !full_seen_q;

    // Memory output is already one clock behind the address
    assign out.data = mem.rd_data;
    // The whole window carries the dest of its trigger sample
    assign out.dest = capture_dest;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= IDLE;
            rd_cnt <= '0;
            full_seen <= 1'b0;
            full_seen_q <= 1'b0;
            out.valid <= 1'b0;
            out.last <= 1'b0;
            mem.rearm <= 1'b0;
            mem.rd_addr <= '0;
        end else begin
            full_seen <= mem.full;
            full_seen_q <= full_seen;
            // Valid and last trail the address by one clock to match the read latency
            out.valid <= (state == READ);
            out.last <= (state == READ) && (rd_cnt == buf_addr_t'(BUF_DEPTH - 1));
            // DONE follows the last address, so rearm lands one clock after last
            mem.rearm <= (state == DONE);
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= READ;
                        mem.rd_addr <= mem.start_addr;
                        rd_cnt <= '0;
                    end
                end
                READ: begin
                    // The index wraps with the buffer
                    mem.rd_addr <= mem.rd_addr + 1'b1;
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == buf_addr_t'(BUF_DEPTH - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/dma_writer.sv ====
//----------------------------
// Packs four samples into each 64-bit write beat
// Write port has no back-pressure
// dma_base_addr is sampled per beat, change it only between captures
//----------------------------
module dma_writer (
    input  logic             clock,
    input  logic             rst_n,
    sample_stream_if.sink    in,
    input  scope_pkg::addr_t dma_base_addr,
    output logic             wr_valid,
    output scope_pkg::addr_t wr_addr,
    output scope_pkg::beat_t wr_data,
    output scope_pkg::dest_t wr_dest,
    output logic             dma_done
);
    import scope_pkg::*;

    logic [LANE_BITS-1:0] lane;
    beat_t beat_q;
    beat_t beat_next;
    addr_t addr_ofs;
    logic beat_end;

    // New samples enter at the top, so the first one of a beat ends in bits 15:0
    assign beat_next = {in.data, beat_q[$bits(beat_t)-1:$bits(sample_t)]};

    // This sample fills the final lane
    assign beat_end = in.valid && (lane == LANE_BITS'(SAMPLES_PER_BEAT - 1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            lane <= '0;
            addr_ofs <= '0;
            wr_valid <= 1'b0;
            dma_done <= 1'b0;
        end else begin
            wr_valid <= beat_end;
            dma_done <= beat_end && in.last;
            if (in.valid) begin
                // A short window still restarts packing at lane 0
                lane <= in.last ? '0 : lane + 1'b1;
            end
            if (beat_end) begin
                // Offset advances one beat in bytes and restarts after the last beat
                addr_ofs <= in.last ? '0 : addr_ofs + addr_t'($bits(beat_t) / 8);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in.valid) begin
            beat_q <= beat_next;
        end
        if (beat_end) begin
            wr_data <= beat_next;
            wr_addr <= dma_base_addr + addr_ofs;
            wr_dest <= in.dest;
        end
    end

endmodule

// ==== design/scope_capture_top.sv ====
//----------------------------
// Triggered capture front end with DMA write-out
// From the rise of full, dma_done follows 67 clocks later
//----------------------------
module scope_capture_top (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  scope_pkg::sample_t   in_data,
    input  scope_pkg::dest_t     in_dest,
    input  logic                 trigger,
    input  scope_pkg::buf_addr_t trigger_point,
    input  scope_pkg::addr_t     dma_base_addr,
    output logic                 wr_valid,
    output scope_pkg::addr_t     wr_addr,
    output scope_pkg::beat_t     wr_data,
    output scope_pkg::dest_t     wr_dest,
    output logic                 dma_done,
    output logic                 full
);
    import scope_pkg::*;

    capture_mem_if mem_if ();
    sample_stream_if stream_if ();

    // Dest of the trigger sample, held for the whole replay
    dest_t capture_dest;

    assign full = mem_if.full;

    capture_buffer capture_buffer0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_dest       (in_dest),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .mem           (mem_if.buffer),
        .capture_dest  (capture_dest)
    );

    capture_readout capture_readout0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .mem          (mem_if.reader),
        .capture_dest (capture_dest),
        .out          (stream_if.source)
    );

    dma_writer dma_writer0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .in            (stream_if.sink),
        .dma_base_addr (dma_base_addr),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_dest       (wr_dest),
        .dma_done      (dma_done)
    );

endmodule

// ==== dv/scope_capture_tb.sv ====
//----------------------------
// Directed testbench for the scope capture front end
// Source ramp counts offered samples, so dropped ones leave gaps
// Stops at the first mismatch and a watchdog bounds the run
//----------------------------
module scope_capture_tb;
    import scope_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    // Two clocks to see full, one window of samples, one clock to pack the last beat
    localparam int FULL_TO_DONE = 2 + BUF_DEPTH + 1;
    localparam int CAPTURE_CYCLES = 200;
    localparam int CAPTURE_COUNT = 6;
    localparam int WATCHDOG_CYCLES = CAPTURE_COUNT * CAPTURE_CYCLES + 400;

    logic clock;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    sample_t in_data;
    dest_t in_dest;
    logic trigger;
    buf_addr_t trigger_point;
    addr_t dma_base_addr;
    logic wr_valid;
    addr_t wr_addr;
    beat_t wr_data;
    dest_t wr_dest;
    logic dma_done;
    logic full;

    integer seed;
    int errors;
    int cyc;
    int ramp;
    int since_arm;
    logic stream_on;
    logic gaps;
    logic dropped_any;
    // Every accepted sample with its dest and the clock edge that took it
    sample_t acc_val[$];
    dest_t acc_dest[$];
    int acc_edge[$];
    // Beats seen on the write port during the current capture
    beat_t beat_data[$];
    addr_t beat_addr[$];
    dest_t beat_dest[$];

    scope_capture_top dut0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_dest       (in_dest),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .dma_base_addr (dma_base_addr),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_dest       (wr_dest),
        .dma_done      (dma_done),
        .full          (full)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cyc <= cyc + 1;
    end

    // The ramp counter moves on after every offered sample, taken or not
    always @(posedge clock) begin
        #DRIVE_DELAY;
        if (in_valid) begin
            ramp = ramp + 1;
        end
        in_valid = stream_on && (!gaps || (($random(seed) & 3) != 0));
        in_data = sample_t'(ramp);
        in_dest = dest_t'(ramp) ^ 8'ha5;
    end

    // Outputs are read half a cycle away from the driving edge
    always @(negedge clock) begin
        // The buffer clears its history count when it leaves hold
        if (!rst_n || !in_ready) begin
            since_arm = 0;
        end else if (in_valid) begin
            since_arm = since_arm + 1;
            acc_val.push_back(in_data);
            acc_dest.push_back(in_dest);
            acc_edge.push_back(cyc + 1);
        end
        if (rst_n && wr_valid) begin
            beat_data.push_back(wr_data);
            beat_addr.push_back(wr_addr);
            beat_dest.push_back(wr_dest);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic step();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERR %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Triggers one capture and checks all beats against the accepted sample log
    task automatic run_capture(input buf_addr_t tp, input addr_t base);
        int t_edge;
        int rise_cyc;
        int pos;
        int first;
        int i;
        int k;
        int j;
        beat_t expect_beat;
        trigger_point = tp;
        dma_base_addr = base;
        beat_data.delete();
        beat_addr.delete();
        beat_dest.delete();
        dropped_any = 1'b0;
        rise_cyc = -1;
        // A margin of two samples keeps the strobe clear of the history limit
        while (since_arm < int'(tp) + 2) begin
            @(negedge clock);
        end
        step();
        trigger = 1'b1;
        t_edge = cyc + 1;
        step();
        trigger = 1'b0;
        while (dma_done !== 1'b1) begin
            @(negedge clock);
            if (full === 1'b1) begin
                if (rise_cyc < 0) begin
                    rise_cyc = cyc;
                end
                check("in_ready while full", 64'(in_ready), 64'(0));
                if (in_valid) begin
                    dropped_any = 1'b1;
                end
            end
        end
        check("wr_valid with dma_done", 64'(wr_valid), 64'(1));
        check("cycles from full to dma_done", 64'(cyc - rise_cyc), 64'(FULL_TO_DONE));
        // Give the monitor the final beat before reading the queues
        @(posedge clock);
        // T is the first sample taken on the strobe edge or later
        pos = -1;
        for (i = 0; i < acc_edge.size(); i++) begin
            if (pos < 0 && acc_edge[i] >= t_edge) begin
                pos = i;
            end
        end
        first = pos - int'(tp);
        check("beat count", 64'(beat_data.size()), 64'(BUF_DEPTH / SAMPLES_PER_BEAT));
        for (k = 0; k < beat_data.size(); k++) begin
            for (j = 0; j < SAMPLES_PER_BEAT; j++) begin
                expect_beat[16*j +: 16] = acc_val[first + SAMPLES_PER_BEAT * k + j];
            end
            check("beat data", beat_data[k], expect_beat);
            check("beat address", 64'(beat_addr[k]), 64'(base + addr_t'(8 * k)));
            check("beat dest", 64'(beat_dest[k]), 64'(acc_dest[pos]));
        end
    endtask

    task automatic check_reset_state();
        @(negedge clock);
        check("full after reset", 64'(full), 64'(0));
        check("wr_valid after reset", 64'(wr_valid), 64'(0));
        check("dma_done after reset", 64'(dma_done), 64'(0));
        check("in_ready after reset", 64'(in_ready), 64'(1));
    endtask

    task automatic capture_continuous();
        @(negedge clock);
        gaps = 1'b0;
        stream_on = 1'b1;
        run_capture(buf_addr_t'(17), 32'h1000_0000);
    endtask

    task automatic early_trigger_ignored();
        @(negedge clock);
        stream_on = 1'b0;
        trigger_point = buf_addr_t'(20);
        repeat (2) step();
        check("history below trigger point", 64'(since_arm < 20), 64'(1));
        trigger = 1'b1;
        step();
        trigger = 1'b0;
        @(negedge clock);
        stream_on = 1'b1;
        // Enough samples to finish any window that the early strobe might have opened
        repeat (BUF_DEPTH + 8) begin
            @(negedge clock);
            check("full after early trigger", 64'(full), 64'(0));
        end
        run_capture(buf_addr_t'(20), 32'h2000_0000);
    endtask

    task automatic hold_drops_input();
        run_capture(buf_addr_t'(8), 32'h3000_0000);
        check("samples offered during hold", 64'(dropped_any), 64'(1));
        // The next window is predicted from the accepted samples alone
        run_capture(buf_addr_t'(48), 32'h3000_1000);
    endtask

    task automatic repeated_captures();
        @(negedge clock);
        gaps = 1'b1;
        run_capture(buf_addr_t'(0), 32'h4000_0000);
        run_capture(buf_addr_t'(BUF_DEPTH - 1), 32'h5000_0000);
    endtask

    initial begin
        seed = 32'h5360;
        errors = 0;
        cyc = 0;
        ramp = 0;
        since_arm = 0;
        stream_on = 1'b0;
        gaps = 1'b0;
        dropped_any = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_dest = '0;
        trigger = 1'b0;
        trigger_point = '0;
        dma_base_addr = '0;
        repeat (8) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_reset_state();
        capture_continuous();
        early_trigger_ignored();
        hold_drops_input();
        repeated_captures();
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/scope_pkg.sv
design/capture_mem_if.sv
design/sample_stream_if.sv
design/capture_buffer.sv
design/capture_readout.sv
design/dma_writer.sv
design/scope_capture_top.sv
dv/scope_capture_tb.sv

// ==== Makefile ====
# Verilator build and run for the scope capture testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= scope_capture_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
